// ==== vlog.f ====
+incdir+rtl
rtl/stats_pkg.sv
rtl/stats_arbiter.sv
rtl/stats_regfile.sv
rtl/stats_clear_counter.sv
rtl/status_bus_fsm.sv
rtl/stats_status_top.sv
bench/stats_status_assert.sv
bench/tb_stats_status.sv

// ==== bench/tb_stats_status.sv ====
`timescale 1ns/1ps
`include "stats_defines.svh"

module tb_stats_status;
   import stats_pkg::*;

   localparam int SRC_N   = `STAT_SRC_N;
   localparam int DEPTH   = `STAT_DEPTH;
   localparam int MAX_REC = 32;
   localparam int RD_WAIT = 4;
   localparam int RD_CYC  = RD_WAIT + 1;
   // five full read sweeps, every record, the clear and its polling
   localparam int TIMEOUT_CYC = 5 * DEPTH * RD_CYC + 4 * MAX_REC + 4 * DEPTH + 100;

   logic                               clk_status = 1'b0;
   logic                               rst_n_i;
   logic [SRC_N-1:0]                   stats_valid_i;
   logic [SRC_N-1:0]                   stats_ready_o;
   stat_op_e [SRC_N-1:0]               stats_op_i;
   logic [SRC_N-1:0][`STAT_ADDR_W-1:0] stats_addr_i;
   stat_payload_u [SRC_N-1:0]          stats_payload_i;
   logic [`STAT_BUS_ADDR_W-1:0]        status_addr_i;
   logic                               status_read_i;
   logic                               status_write_i;
   logic [`STAT_DATA_W-1:0]            status_writedata_i;
   logic [`STAT_DATA_W-1:0]            status_readdata_o;
   logic                               status_readdata_valid_o;

   // record table, one row per index
   int          tbl_src [MAX_REC];
   stat_op_e    tbl_op [MAX_REC];
   logic [7:0]  tbl_addr [MAX_REC];
   logic [31:0] tbl_pay [MAX_REC];
   int          nrec;
   int          ph_multi;
   int          ph_held;

   logic [31:0] model [DEPTH];
   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;

   stats_status_top dut (
      .clk_status              (clk_status),
      .rst_n_i                 (rst_n_i),
      .stats_valid_i           (stats_valid_i),
      .stats_ready_o           (stats_ready_o),
      .stats_op_i              (stats_op_i),
      .stats_addr_i            (stats_addr_i),
      .stats_payload_i         (stats_payload_i),
      .status_addr_i           (status_addr_i),
      .status_read_i           (status_read_i),
      .status_write_i          (status_write_i),
      .status_writedata_i      (status_writedata_i),
      .status_readdata_o       (status_readdata_o),
      .status_readdata_valid_o (status_readdata_valid_o)
   );

   always #5 clk_status = ~clk_status;

   always @(posedge clk_status) begin
      cycles = cycles + 1;
      if (cycles > TIMEOUT_CYC) begin
         $display("run timed out after %0d cycles", cycles);
         $display("errors: %0d of %0d checks", errors, checks);
         $display("=== FAIL ===");
         $finish;
      end
   end

   task automatic add_rec(input int src, input stat_op_e op, input logic [7:0] addr,
                          input logic [31:0] pay);
      tbl_src[nrec]  = src;
      tbl_op[nrec]   = op;
      tbl_addr[nrec] = addr;
      tbl_pay[nrec]  = pay;
      nrec++;
   endtask

   task automatic build_table();
      nrec = 0;
      // word 5 wraps past 2^32
      add_rec(0, STAT_ADD, 8'd5, 32'hffff_fff0);
      add_rec(0, STAT_ADD, 8'd5, 32'h0000_0025);
      add_rec(0, STAT_ADD, 8'd6, $urandom);
      add_rec(0, STAT_ADD, 8'd6, $urandom);
      add_rec(0, STAT_ADD, 8'd6, $urandom);
      // tag half is noise, level in the low half
      add_rec(1, STAT_MAX, 8'd10, {16'($urandom), 16'h0100});
      add_rec(1, STAT_MAX, 8'd10, {16'($urandom), 16'h0800});
      add_rec(1, STAT_MAX, 8'd10, {16'($urandom), 16'h0300});
      add_rec(1, STAT_MAX, 8'd11, {16'hffff, 16'h0001});
      ph_multi = nrec;
      for (int i = 0; i < 4; i++) begin
         add_rec(0, STAT_ADD, 8'd20, $urandom);
         add_rec(1, STAT_ADD, 8'd20, $urandom);
         add_rec(2, STAT_MAX, 8'd21, {16'($urandom), 16'($urandom)});
      end
      ph_held = nrec;
      add_rec(0, STAT_ADD, 8'd30, $urandom);
      add_rec(1, STAT_MAX, 8'd31, {16'($urandom), 16'($urandom)});
      add_rec(2, STAT_ADD, 8'd63, $urandom);
   endtask

   task automatic apply_model(input int i);
      logic [31:0] lvl;
      lvl = {16'h0000, tbl_pay[i][15:0]};
      if (tbl_addr[i] != 8'd0) begin
         if (tbl_op[i] == STAT_ADD) begin
            model[tbl_addr[i]] = model[tbl_addr[i]] + tbl_pay[i];
         end else if (lvl > model[tbl_addr[i]]) begin
            model[tbl_addr[i]] = lvl;
         end
      end
   endtask

   function automatic int find_next(input int src, input int from, input int last);
      for (int i = from; i < last; i++) begin
         if (tbl_src[i] == src) begin
            return i;
         end
      end
      return -1;
   endfunction

   // each source holds its record until it sees ready
   task automatic run_records(input int first, input int last);
      int               cur [SRC_N];
      logic [SRC_N-1:0] rdy;
      bit               pending;
      for (int s = 0; s < SRC_N; s++) begin
         cur[s] = find_next(s, first, last);
      end
      pending = 1'b1;
      while (pending) begin
         @(negedge clk_status);
         pending = 1'b0;
         for (int s = 0; s < SRC_N; s++) begin
            stats_valid_i[s] = (cur[s] >= 0);
            if (cur[s] >= 0) begin
               stats_op_i[s]      = tbl_op[cur[s]];
               stats_addr_i[s]    = tbl_addr[cur[s]];
               stats_payload_i[s] = tbl_pay[cur[s]];
               pending            = 1'b1;
            end
         end
         #1;
         rdy = stats_ready_o;
         for (int s = 0; s < SRC_N; s++) begin
            if (rdy[s] && cur[s] < 0) begin
               errors++;
               $display("ready raised toward source %0d which has no record", s);
            end else if (rdy[s]) begin
               apply_model(cur[s]);
               cur[s] = find_next(s, cur[s] + 1, last);
            end
         end
      end
   endtask

   task automatic bus_read(input logic [3:0] sel, input int idx, output logic [31:0] data,
                           output int lat);
      int n;
      @(negedge clk_status);
      status_addr_i = '0;
      status_addr_i[`STAT_BUS_ADDR_W-1 -: `STAT_SEL_W] = sel;
      status_addr_i[`STAT_ADDR_W-1:0] = idx[`STAT_ADDR_W-1:0];
      status_read_i = 1'b1;
      data = 'x;
      lat  = 0;
      n    = 0;
      while (lat == 0 && n < RD_WAIT) begin
         @(negedge clk_status);
         status_read_i = 1'b0;
         n++;
         if (status_readdata_valid_o) begin
            lat  = n;
            data = status_readdata_o;
         end
      end
   endtask

   task automatic bus_write(input int idx, input logic [31:0] data);
      @(negedge clk_status);
      status_addr_i = '0;
      status_addr_i[`STAT_BUS_ADDR_W-1 -: `STAT_SEL_W] = `TOP_REG;
      status_addr_i[`STAT_ADDR_W-1:0] = idx[`STAT_ADDR_W-1:0];
      status_writedata_i = data;
      status_write_i     = 1'b1;
      @(negedge clk_status);
      status_write_i = 1'b0;
   endtask

   task automatic check_read(input string name, input int idx, input logic [31:0] exp);
      logic [31:0] data;
      int          lat;
      bus_read(`TOP_REG, idx, data, lat);
      checks++;
      // third falling edge is two rising edges after the strobe edge
      if (lat == 0) begin
         errors++;
         $display("%s: no readdata_valid for index %0d", name, idx);
      end else if (lat != 3) begin
         errors++;
         $display("[ERROR] %s latency idx %0d expected 3 actual %0d", name, idx, lat);
      end else if (data !== exp) begin
         errors++;
         $display("[ERROR] %s idx %0d expected %h actual %h", name, idx, exp, data);
      end
   endtask

   task automatic check_all(input string name);
      for (int i = 1; i < DEPTH; i++) begin
         check_read(name, i, model[i]);
      end
   endtask

   task automatic wait_clear_done();
      logic [31:0] data;
      int          lat;
      int          polls;
      polls = 0;
      data  = 32'h1;
      while (data[`CTRL_CLEAR_BIT] !== 1'b0 && polls < DEPTH) begin
         bus_read(`TOP_REG, `REG_CTRL, data, lat);
         polls++;
      end
      checks++;
      if (data[`CTRL_CLEAR_BIT] !== 1'b0) begin
         errors++;
         $display("clear sweep still busy after %0d control reads", polls);
      end
   endtask

   initial begin
      logic [31:0] data;
      int          lat;
      void'($urandom(15));
      rst_n_i            = 1'b0;
      stats_valid_i      = '0;
      stats_addr_i       = '0;
      stats_payload_i    = '0;
      status_addr_i      = '0;
      status_read_i      = 1'b0;
      status_write_i     = 1'b0;
      status_writedata_i = '0;
      for (int s = 0; s < SRC_N; s++) begin
         stats_op_i[s] = STAT_ADD;
      end
      for (int i = 0; i < DEPTH; i++) begin
         model[i] = '0;
      end
      build_table();
      repeat (3) @(negedge clk_status);
      rst_n_i = 1'b1;

      @(negedge clk_status);
      checks++;
      if (status_readdata_valid_o !== 1'b0) begin
         errors++;
         $display("[ERROR] reset_valid expected 0 actual %b", status_readdata_valid_o);
      end
      check_read("reset_ctrl", `REG_CTRL, 32'h0);
      check_all("reset");

      run_records(0, ph_multi);
      check_read("add_wrap", 5, 32'h0000_0015);
      check_read("max_keep", 10, 32'h0000_0800);
      check_all("add_max");

      run_records(ph_multi, ph_held);
      check_all("three_src");

      // records start only once the sweep is seen running
      bus_write(`REG_CTRL, 32'h0000_a5a1);
      check_read("ctrl_busy", `REG_CTRL, 32'h0000_a5a1);
      for (int i = 0; i < DEPTH; i++) begin
         model[i] = '0;
      end
      fork
         run_records(ph_held, nrec);
         wait_clear_done();
      join
      repeat (2) @(negedge clk_status);
      check_read("ctrl_done", `REG_CTRL, 32'h0000_a5a0);
      check_all("after_clear");

      bus_read(`TOP_REG + 4'h1, 5, data, lat);
      checks++;
      if (lat != 0) begin
         errors++;
         $display("read with a foreign selector produced readdata_valid");
      end
      check_read("sel_hit", 5, model[5]);

      errors = errors + int'(dut.u_assert.fail_cnt);
      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// ==== bench/stats_status_assert.sv ====
`timescale 1ns/1ps
`include "stats_defines.svh"

module stats_status_assert (
   input logic                   clk_status,
   input logic                   rst_n_i,
   input logic [`STAT_SRC_N-1:0] stats_ready_i,
   input logic                   readdata_valid_i,
   input logic                   clear_busy_i
);

   int unsigned fail_cnt = 0;

   // one grant per cycle at most
   a_ready_onehot : assert property (
      @(posedge clk_status) disable iff (!rst_n_i) $onehot0(stats_ready_i)
   ) else begin
      fail_cnt++;
      $error("stats_ready_o has more than one bit set: %b", stats_ready_i);
   end

   a_rdv_pulse : assert property (
      @(posedge clk_status) disable iff (!rst_n_i) readdata_valid_i |=> !readdata_valid_i
   ) else begin
      fail_cnt++;
      $error("status_readdata_valid_o stayed high for more than one cycle");
   end

   // producers held off during the sweep
   a_no_ready_in_clear : assert property (
      @(posedge clk_status) disable iff (!rst_n_i) clear_busy_i |-> (stats_ready_i == '0)
   ) else begin
      fail_cnt++;
      $error("stats_ready_o raised while the clear sweep runs: %b", stats_ready_i);
   end

endmodule

bind stats_status_top stats_status_assert u_assert (
   .clk_status       (clk_status),
   .rst_n_i          (rst_n_i),
   .stats_ready_i    (stats_ready_o),
   .readdata_valid_i (status_readdata_valid_o),
   .clear_busy_i     (clear_busy)
);

// ==== rtl/stats_status_top.sv ====
`timescale 1ns/1ps
`include "stats_defines.svh"

module stats_status_top (
   input  logic                                       clk_status,
   input  logic                                       rst_n_i,
   input  logic [`STAT_SRC_N-1:0]                     stats_valid_i,
   output logic [`STAT_SRC_N-1:0]                     stats_ready_o,
   input  stats_pkg::stat_op_e [`STAT_SRC_N-1:0]      stats_op_i,
   input  logic [`STAT_SRC_N-1:0][`STAT_ADDR_W-1:0]   stats_addr_i,
   input  stats_pkg::stat_payload_u [`STAT_SRC_N-1:0] stats_payload_i,
   input  logic [`STAT_BUS_ADDR_W-1:0]                status_addr_i,
   input  logic                                       status_read_i,
   input  logic                                       status_write_i,
   input  logic [`STAT_DATA_W-1:0]                    status_writedata_i,
   output logic [`STAT_DATA_W-1:0]                    status_readdata_o,
   output logic                                       status_readdata_valid_o
);
   import stats_pkg::*;

   logic                    upd_valid;
   stat_op_e                upd_op;
   logic [`STAT_ADDR_W-1:0] upd_addr;
   stat_payload_u           upd_payload;

   logic                    clear_start;
   logic                    clear_busy;
   logic                    clr_en;
   logic [`STAT_ADDR_W-1:0] clr_addr;

   logic [`STAT_ADDR_W-1:0] rd_addr;
   logic [`STAT_DATA_W-1:0] rd_data;

   // producers are held off while the sweep runs
   stats_arbiter u_arbiter (
      .clk_status      (clk_status),
      .rst_n_i         (rst_n_i),
      .stats_valid_i   (stats_valid_i),
      .stats_op_i      (stats_op_i),
      .stats_addr_i    (stats_addr_i),
      .stats_payload_i (stats_payload_i),
      .stall_i         (clear_busy),
      .stats_ready_o   (stats_ready_o),
      .upd_valid_o     (upd_valid),
      .upd_op_o        (upd_op),
      .upd_addr_o      (upd_addr),
      .upd_payload_o   (upd_payload)
   );

   stats_regfile u_regfile (
      .clk_status    (clk_status),
      .rst_n_i       (rst_n_i),
      .upd_valid_i   (upd_valid),
      .upd_op_i      (upd_op),
      .upd_addr_i    (upd_addr),
      .upd_payload_i (upd_payload),
      .clr_en_i      (clr_en),
      .clr_addr_i    (clr_addr),
      .rd_addr_i     (rd_addr),
      .rd_data_o     (rd_data)
   );

   stats_clear_counter u_clear_counter (
      .clk_status    (clk_status),
      .rst_n_i       (rst_n_i),
      .clear_start_i (clear_start),
      .clear_busy_o  (clear_busy),
      .clr_en_o      (clr_en),
      .clr_addr_o    (clr_addr)
   );

   status_bus_fsm u_bus_fsm (
      .clk_status              (clk_status),
      .rst_n_i                 (rst_n_i),
      .status_addr_i           (status_addr_i),
      .status_read_i           (status_read_i),
      .status_write_i          (status_write_i),
      .status_writedata_i      (status_writedata_i),
      .rd_data_i               (rd_data),
      .clear_busy_i            (clear_busy),
      .rd_addr_o               (rd_addr),
      .clear_start_o           (clear_start),
      .status_readdata_o       (status_readdata_o),
      .status_readdata_valid_o (status_readdata_valid_o)
   );

endmodule

// ==== rtl/status_bus_fsm.sv ====
`timescale 1ns/1ps
`include "stats_defines.svh"

module status_bus_fsm (
   input  logic                        clk_status,
   input  logic                        rst_n_i,
   input  logic [`STAT_BUS_ADDR_W-1:0] status_addr_i,
   input  logic                        status_read_i,
   input  logic                        status_write_i,
   input  logic [`STAT_DATA_W-1:0]     status_writedata_i,
   input  logic [`STAT_DATA_W-1:0]     rd_data_i,
   input  logic                        clear_busy_i,
   output logic [`STAT_ADDR_W-1:0]     rd_addr_o,
   output logic                        clear_start_o,
   output logic [`STAT_DATA_W-1:0]     status_readdata_o,
   output logic                        status_readdata_valid_o
);

   // idle stage, raw bus capture
   logic [`STAT_SEL_W-1:0]  cap_sel_q;
   logic [`STAT_ADDR_W-1:0] cap_idx_q;
   logic                    cap_rd_q;
   logic                    cap_wr_q;
   logic [`STAT_DATA_W-1:0] cap_wdata_q;

   // decode stage, selector already matched
   logic [`STAT_ADDR_W-1:0] dec_idx_q;
   logic                    dec_rd_q;
   logic                    dec_wr_q;
   logic [`STAT_DATA_W-1:0] dec_wdata_q;

   logic [`STAT_DATA_W-1:0] ctrl_q;
   logic [`STAT_DATA_W-1:0] ctrl_rd;
   logic                    sel_hit;
   logic                    dec_is_ctrl;
   logic                    ctrl_wr;

   assign sel_hit     = (cap_sel_q == `TOP_REG);
   assign dec_is_ctrl = (dec_idx_q == `REG_CTRL);
   assign ctrl_wr     = dec_wr_q && dec_is_ctrl;

   // writes to statistics indexes fall through here
   assign clear_start_o = ctrl_wr && dec_wdata_q[`CTRL_CLEAR_BIT];
   assign rd_addr_o     = dec_idx_q;

   // bit 0 shows the sweep in progress
   always_comb begin
      ctrl_rd                  = ctrl_q;
      ctrl_rd[`CTRL_CLEAR_BIT] = clear_busy_i;
   end

   always_ff @(posedge clk_status) begin
      if (!rst_n_i) begin
         cap_rd_q                <= 1'b0;
         cap_wr_q                <= 1'b0;
         dec_rd_q                <= 1'b0;
         dec_wr_q                <= 1'b0;
         status_readdata_valid_o <= 1'b0;
         ctrl_q                  <= '0;
      end else begin
         cap_rd_q                <= status_read_i;
         cap_wr_q                <= status_write_i;
         dec_rd_q                <= cap_rd_q && sel_hit;
         dec_wr_q                <= cap_wr_q && sel_hit;
         status_readdata_valid_o <= dec_rd_q;
         if (ctrl_wr) begin
            ctrl_q <= dec_wdata_q;
         end
      end
   end

   always_ff @(posedge clk_status) begin
      cap_sel_q   <= status_addr_i[`STAT_BUS_ADDR_W-1 -: `STAT_SEL_W];
      cap_idx_q   <= status_addr_i[`STAT_ADDR_W-1:0];
      cap_wdata_q <= status_writedata_i;
      dec_idx_q   <= cap_idx_q;
      dec_wdata_q <= cap_wdata_q;
      // respond stage
      if (dec_rd_q) begin
         status_readdata_o <= dec_is_ctrl ? ctrl_rd : rd_data_i;
      end
   end

endmodule

// ==== rtl/stats_clear_counter.sv ====
`timescale 1ns/1ps
`include "stats_defines.svh"

module stats_clear_counter (
   input  logic                    clk_status,
   input  logic                    rst_n_i,
   input  logic                    clear_start_i,
   output logic                    clear_busy_o,
   output logic                    clr_en_o,
   output logic [`STAT_ADDR_W-1:0] clr_addr_o
);

   localparam logic [`STAT_ADDR_W-1:0] FIRST_IDX = `STAT_ADDR_W'(1);
   localparam logic [`STAT_ADDR_W-1:0] LAST_IDX  = `STAT_ADDR_W'(`STAT_DEPTH - 1);

   logic                    busy_q;
   logic [`STAT_ADDR_W-1:0] addr_q;

   // sweep 1..depth-1, starts are dropped while running
   always_ff @(posedge clk_status) begin
      if (!rst_n_i) begin
         busy_q <= 1'b0;
         addr_q <= '0;
      end else if (!busy_q) begin
         if (clear_start_i) begin
            busy_q <= 1'b1;
            addr_q <= FIRST_IDX;
         end
      end else if (addr_q == LAST_IDX) begin
         busy_q <= 1'b0;
      end else begin
         addr_q <= addr_q + 1'b1;
      end
   end

   assign clear_busy_o = busy_q;
   assign clr_en_o     = busy_q;
   assign clr_addr_o   = addr_q;

endmodule

// ==== rtl/stats_regfile.sv ====
`timescale 1ns/1ps
`include "stats_defines.svh"

module stats_regfile (
   input  logic                      clk_status,
   input  logic                      rst_n_i,
   input  logic                      upd_valid_i,
   input  stats_pkg::stat_op_e       upd_op_i,
   input  logic [`STAT_ADDR_W-1:0]   upd_addr_i,
   input  stats_pkg::stat_payload_u  upd_payload_i,
   input  logic                      clr_en_i,
   input  logic [`STAT_ADDR_W-1:0]   clr_addr_i,
   input  logic [`STAT_ADDR_W-1:0]   rd_addr_i,
   output logic [`STAT_DATA_W-1:0]   rd_data_o
);
   import stats_pkg::*;

   localparam int IDX_W  = $clog2(`STAT_DEPTH);
   localparam int HALF_W = `STAT_DATA_W / 2;

   logic [`STAT_DATA_W-1:0] mem [`STAT_DEPTH];

   logic [IDX_W-1:0]        upd_idx;
   logic [IDX_W-1:0]        clr_idx;
   logic [IDX_W-1:0]        rd_idx;
   logic                    upd_hit;
   logic                    clr_hit;
   logic [`STAT_DATA_W-1:0] upd_old;
   logic [`STAT_DATA_W-1:0] max_level;
   logic [`STAT_DATA_W-1:0] next_word;

   assign upd_idx = upd_addr_i[IDX_W-1:0];
   assign clr_idx = clr_addr_i[IDX_W-1:0];
   assign rd_idx  = rd_addr_i[IDX_W-1:0];

   // index 0 belongs to the control register
   assign upd_hit = upd_valid_i && (upd_addr_i != `REG_CTRL) && (upd_addr_i < `STAT_DEPTH);
   assign clr_hit = (clr_addr_i != `REG_CTRL) && (clr_addr_i < `STAT_DEPTH);

   assign upd_old   = mem[upd_idx];
   assign max_level = {{HALF_W{1'b0}}, upd_payload_i.lvl.level};

   always_comb begin
      next_word = upd_old;
      unique case (upd_op_i)
         STAT_ADD: next_word = upd_old + upd_payload_i.incr;
         STAT_MAX: begin
            // tag half is ignored
            if (max_level > upd_old) begin
               next_word = max_level;
            end
         end
      endcase
   end

   // clear wins over an update in the same cycle
   always_ff @(posedge clk_status) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `STAT_DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (clr_en_i) begin
         if (clr_hit) begin
            mem[clr_idx] <= '0;
         end
      end else if (upd_hit) begin
         mem[upd_idx] <= next_word;
      end
   end

   assign rd_data_o = (rd_addr_i < `STAT_DEPTH) ? mem[rd_idx] : '0;

endmodule

// ==== rtl/stats_arbiter.sv ====
`timescale 1ns/1ps
`include "stats_defines.svh"

module stats_arbiter (
   input  logic                                      clk_status,
   input  logic                                      rst_n_i,
   input  logic [`STAT_SRC_N-1:0]                    stats_valid_i,
   input  stats_pkg::stat_op_e [`STAT_SRC_N-1:0]     stats_op_i,
   input  logic [`STAT_SRC_N-1:0][`STAT_ADDR_W-1:0]  stats_addr_i,
   input  stats_pkg::stat_payload_u [`STAT_SRC_N-1:0] stats_payload_i,
   input  logic                                      stall_i,
   output logic [`STAT_SRC_N-1:0]                    stats_ready_o,
   output logic                                      upd_valid_o,
   output stats_pkg::stat_op_e                       upd_op_o,
   output logic [`STAT_ADDR_W-1:0]                   upd_addr_o,
   output stats_pkg::stat_payload_u                  upd_payload_o
);

   localparam int SRC_N = `STAT_SRC_N;
   localparam int SRC_W = $clog2(SRC_N);

   logic [SRC_W-1:0] last_q;
   logic [SRC_W-1:0] win_idx;
   logic             win_found;
   logic             take;

   // search starts one past the last winner
   always_comb begin
      int unsigned cand;
      win_idx   = last_q;
      win_found = 1'b0;
      for (int i = 1; i <= SRC_N; i++) begin
         cand = (int'(last_q) + i) % SRC_N;
         if (!win_found && stats_valid_i[cand]) begin
            win_found = 1'b1;
            win_idx   = SRC_W'(cand);
         end
      end
   end

   assign take = win_found && !stall_i;

   // ready only toward the winner
   always_comb begin
      stats_ready_o          = '0;
      stats_ready_o[win_idx] = take;
   end

   always_ff @(posedge clk_status) begin
      if (!rst_n_i) begin
         upd_valid_o <= 1'b0;
         last_q      <= SRC_W'(SRC_N - 1);
      end else begin
         upd_valid_o <= take;
         if (take) begin
            last_q <= win_idx;
         end
      end
   end

   // winning record, one pulse per transfer
   always_ff @(posedge clk_status) begin
      if (take) begin
         upd_op_o      <= stats_op_i[win_idx];
         upd_addr_o    <= stats_addr_i[win_idx];
         upd_payload_o <= stats_payload_i[win_idx];
      end
   end

endmodule

// ==== rtl/stats_pkg.sv ====
`include "stats_defines.svh"

package stats_pkg;

   // add a delta, or keep the largest level seen
   typedef enum logic {
      STAT_ADD = 1'b0,
      STAT_MAX = 1'b1
   } stat_op_e;

   // one stats word, decoded by op
   // ADD reads incr, MAX reads lvl and only compares the level half
   typedef union packed {
      logic [`STAT_DATA_W-1:0] incr;
      struct packed {
         logic [`STAT_DATA_W/2-1:0] tag;
         logic [`STAT_DATA_W/2-1:0] level;
      } lvl;
   } stat_payload_u;

endpackage

// ==== rtl/stats_defines.svh ====
`ifndef STATS_DEFINES_SVH
`define STATS_DEFINES_SVH

// statistics word and status data width
`define STAT_DATA_W 32

// register index inside the block
`define STAT_ADDR_W 8

// number of statistics words, index 0 is the control register
`define STAT_DEPTH 64

// block selector in the top bits of the status address
`define STAT_SEL_W 4
`define STAT_BUS_ADDR_W 30

// selector value that maps the status bus onto this block
`define TOP_REG 4'h1

// control register and its fields
`define REG_CTRL 8'h00
`define CTRL_CLEAR_BIT 0

// producer streams feeding the arbiter
`define STAT_SRC_N 3

`endif
